/* sim.f */
src/qspi_pkg.sv
src/qspi_sck_gen.sv
src/qspi_ctrl.sv
src/qspi_shifter.sv
src/qspi_master.sv
testbench/tb_clk_gen.sv
testbench/qspi_chk.sv
testbench/qspi_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= qspi_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/qspi_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module qspi_tb;
    import qspi_pkg::*;

    localparam int SEED       = 32'h3fd54960;
    localparam int RST_CYCLES = 10;
    localparam int CLK_NS     = 20;
    localparam int DIV_TB_MAX = 3;
    localparam int H_MAX      = 1 << DIV_TB_MAX;
    localparam int GAP_MAX    = 20;
    localparam int N_XFER     = 24 + 24 + 16 + 16;
    localparam int TIMEOUT_NS =
        (RST_CYCLES + N_XFER * (2 * BYTE_W * H_MAX + GAP_MAX + 8) + 100) * CLK_NS;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    qspi_req_t req_in;
    qspi_cfg_t cfg_in;
    logic      rsp_ready;
    dq_t       dq_in;
    logic      req_ready;
    logic      rsp_valid;
    byte_t     rsp_data;
    logic      busy;
    qspi_pad_t pad;

    int err_cnt   = 0;
    int check_cnt = 0;
    int xfer_cnt  = 0;
    int rsp_cnt   = 0;
    int total_err;

    tb_clk_gen u_clk_gen (
        .o_clk (clk)
    );

    qspi_master u_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_req_valid (req_valid),
        .i_req       (req_in),
        .i_cfg       (cfg_in),
        .i_rsp_ready (rsp_ready),
        .i_dq        (dq_in),
        .o_req_ready (req_ready),
        .o_rsp_valid (rsp_valid),
        .o_rsp_data  (rsp_data),
        .o_busy      (busy),
        .o_pad       (pad)
    );

    bind qspi_master qspi_chk u_chk (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cfg       (i_cfg),
        .i_rsp_ready (i_rsp_ready),
        .i_rsp_valid (o_rsp_valid),
        .i_rsp_data  (o_rsp_data),
        .i_req_ready (o_req_ready),
        .i_busy      (o_busy),
        .i_pad       (o_pad)
    );

    // --------------------
    // reference model
    // --------------------
    function automatic int lane_bits(input lanes_e lanes);
        case (lanes)
            LANES_DUAL: return 2;
            LANES_QUAD: return 4;
            default:    return 1;                  // unused code runs as single
        endcase
    endfunction

    function automatic int half_period(input div_t div);
        int d;
        d = (int'(div) > DIV_MAX) ? DIV_MAX : int'(div);
        return 1 << d;
    endfunction

    function automatic dq_t expected_oe(input qspi_req_t xfer);
        if (lane_bits(xfer.lanes) == 1) begin
            return 4'b0001;
        end
        if (!xfer.write) begin
            return 4'b0000;
        end
        return (lane_bits(xfer.lanes) == 2) ? 4'b0011 : 4'b1111;
    endfunction

    function automatic logic returns_data(input qspi_req_t xfer, input qspi_cfg_t conf);
        return !xfer.write || ((lane_bits(xfer.lanes) == 1) && conf.duplex);
    endfunction

    // slave reply bits for one slot msb first
    function automatic dq_t pad_drive(input lanes_e lanes, input byte_t reply, input int slot);
        byte_t shifted;
        shifted = reply << (slot * lane_bits(lanes));
        case (lane_bits(lanes))
            2:       return {2'b00, shifted[BYTE_W-1 -: 2]};
            4:       return shifted[BYTE_W-1 -: 4];
            default: return {2'b00, shifted[BYTE_W-1], ~shifted[BYTE_W-1]};  // dq0 inverted
        endcase
    endfunction

    function automatic byte_t capture_bits(input lanes_e lanes, input dq_t dq);
        case (lane_bits(lanes))
            2:       return {6'b0, dq[1:0]};
            4:       return {4'b0, dq};
            default: return {7'b0, dq[0]};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (err_cnt == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - err_start);
        end
    endtask

    // --------------------
    // one transfer
    // --------------------
    task automatic run_transfer(input qspi_req_t xfer, input qspi_cfg_t conf, input int gap,
                                input logic early, input qspi_req_t next_req);
        byte_t reply;
        byte_t cap;
        dq_t   oe_exp;
        int    slots;
        int    half;
        int    busy_cnt;
        int    edge_cnt;
        int    tx_slot;
        int    i;
        logic  cpol;
        logic  cpha;
        logic  prev_sck;
        logic  lead;
        logic  rsp_due;
        logic  done;

        reply    = byte_t'($urandom());
        slots    = BYTE_W / lane_bits(xfer.lanes);
        half     = half_period(conf.div);
        cpol     = conf.mode[1];
        cpha     = conf.mode[0];
        rsp_due  = returns_data(xfer, conf);
        oe_exp   = expected_oe(xfer);
        tx_slot  = cpha ? 0 : 1;                   // cpha=0 needs slot 0 up front
        cap      = '0;
        busy_cnt = 0;
        edge_cnt = 0;
        done     = 1'b0;

        cfg_in    = conf;
        req_in    = xfer;
        dq_in     = pad_drive(xfer.lanes, reply, 0);
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid   = 1'b0;
        req_in.data = ~xfer.data;
        xfer_cnt++;
        prev_sck = cpol;

        while (!done) begin
            if (pad.sck !== prev_sck) begin
                edge_cnt++;
                lead = (pad.sck != cpol);
                if (cpha ? !lead : lead) begin
                    cap = (cap << lane_bits(xfer.lanes)) | capture_bits(xfer.lanes, pad.dq_o);
                end else if (tx_slot < slots) begin
                    dq_in = pad_drive(xfer.lanes, reply, tx_slot);
                    tx_slot++;
                end
                prev_sck = pad.sck;
            end
            if (!busy) begin
                done = 1'b1;
            end else begin
                busy_cnt++;
                check_value("dq_oe", 32'(pad.dq_oe), 32'(oe_exp));
                @(negedge clk);
            end
        end

        check_value("busy_cycles", busy_cnt, 2 * half * slots);
        check_value("sck_edges", edge_cnt, 2 * slots);
        check_value("sck", 32'(pad.sck), 32'(cpol));
        check_value("rsp_valid", 32'(rsp_valid), 32'(rsp_due));
        if (xfer.write) begin
            check_value("slave_byte", 32'(cap), 32'(xfer.data));
        end

        if (rsp_due) begin
            if (early) begin
                req_in    = next_req;              // next request waits behind the response
                req_valid = 1'b1;
            end
            for (i = 0; i <= gap; i++) begin
                if (i > 0) begin
                    @(negedge clk);
                end
                check_value("rsp_valid", 32'(rsp_valid), 32'(1'b1));
                check_value("rsp_data", 32'(rsp_data), 32'(reply));
                check_value("req_ready", 32'(req_ready), 32'(1'b0));
                check_value("busy", 32'(busy), 32'(1'b0));
            end
            rsp_ready = 1'b1;
            @(negedge clk);
            rsp_ready = 1'b0;
            rsp_cnt++;
            check_value("rsp_valid", 32'(rsp_valid), 32'(1'b0));
        end
        check_value("req_ready", 32'(req_ready), 32'(1'b1));
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic test_reset();
        int err_start;
        err_start = err_cnt;
        check_value("busy", 32'(busy), 32'(1'b0));
        check_value("rsp_valid", 32'(rsp_valid), 32'(1'b0));
        check_value("dq_oe", 32'(pad.dq_oe), 32'(4'b0000));
        check_value("sck", 32'(pad.sck), 32'(cfg_in.mode[1]));
        check_value("req_ready", 32'(req_ready), 32'(1'b1));
        report_test("reset", err_start);
    endtask

    // every lane count and mode twice
    task automatic test_sweep(input logic write, input string name);
        qspi_req_t xfer;
        qspi_cfg_t conf;
        int        err_start;
        int        l;
        int        m;
        int        r;
        err_start = err_cnt;
        for (l = 0; l < 3; l++) begin
            for (m = 0; m < 4; m++) begin
                for (r = 0; r < 2; r++) begin
                    xfer.write  = write;
                    xfer.lanes  = lanes_e'(2'(l));
                    xfer.data   = byte_t'($urandom());
                    conf.mode   = spi_mode_t'(m);
                    conf.div    = div_t'($urandom_range(DIV_TB_MAX, 0));
                    conf.duplex = write ? (r == 1) : 1'($urandom_range(1, 0));
                    run_transfer(xfer, conf, $urandom_range(3, 0), 1'b0, '0);
                end
            end
        end
        report_test(name, err_start);
    endtask

    task automatic test_mixed();
        qspi_req_t xfer;
        qspi_cfg_t conf;
        int        err_start;
        int        n;
        err_start = err_cnt;
        for (n = 0; n < 16; n++) begin
            xfer.write  = 1'($urandom_range(1, 0));
            xfer.lanes  = lanes_e'(2'($urandom_range(3, 0)));
            xfer.data   = byte_t'($urandom());
            conf.mode   = spi_mode_t'($urandom_range(3, 0));
            conf.div    = div_t'($urandom_range(DIV_TB_MAX, 0));
            conf.duplex = 1'($urandom_range(1, 0));
            run_transfer(xfer, conf, $urandom_range(3, 0), 1'b0, '0);
        end
        report_test("timing", err_start);
    endtask

    // a request that returns a byte when duplex is set
    function automatic qspi_req_t draw_returning_req();
        qspi_req_t req;
        req.write = 1'($urandom_range(1, 0));
        req.lanes = req.write ? LANES_SINGLE : lanes_e'(2'($urandom_range(2, 0)));
        req.data  = byte_t'($urandom());
        return req;
    endfunction

    task automatic test_backpressure();
        qspi_req_t xfer;
        qspi_req_t next_req;
        qspi_cfg_t conf;
        int        err_start;
        int        n;
        err_start = err_cnt;
        next_req  = draw_returning_req();
        for (n = 0; n < 16; n++) begin
            xfer        = next_req;
            next_req    = draw_returning_req();
            conf.mode   = spi_mode_t'($urandom_range(3, 0));
            conf.div    = div_t'($urandom_range(DIV_TB_MAX, 0));
            conf.duplex = 1'b1;                    // every transfer returns a byte
            run_transfer(xfer, conf, $urandom_range(GAP_MAX, 5), n < 15, next_req);
        end
        report_test("backpressure", err_start);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_in    = '0;
        cfg_in    = '0;
        cfg_in.mode = spi_mode_t'($urandom_range(3, 0));
        rsp_ready = 1'b0;
        dq_in     = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_sweep(1'b1, "writes");
        test_sweep(1'b0, "reads");
        test_mixed();
        test_backpressure();

        total_err = err_cnt + u_dut.u_chk.fail_cnt;
        $write("summary: 5 tests, %0d transfers, %0d responses, %0d checks, ",
               xfer_cnt, rsp_cnt, check_cnt);
        $display("%0d errors, %0d assertion failures", err_cnt, u_dut.u_chk.fail_cnt);
        if (total_err == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // --------------------
    // watchdog
    // --------------------
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/qspi_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module qspi_chk (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  qspi_pkg::qspi_cfg_t i_cfg,
    input  logic                i_rsp_ready,
    input  logic                i_rsp_valid,
    input  qspi_pkg::byte_t     i_rsp_data,
    input  logic                i_req_ready,
    input  logic                i_busy,
    input  qspi_pkg::qspi_pad_t i_pad
);
    int fail_cnt = 0;

    // --------------------
    // response handshake
    // --------------------
    a_rsp_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_rsp_valid && !i_rsp_ready) |=> (i_rsp_valid && $stable(i_rsp_data))
    ) else begin
        fail_cnt++;
        $error("response dropped or changed before it was accepted");
    end

    a_ready_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_busy |-> !i_req_ready
    ) else begin
        fail_cnt++;
        $error("request ready high during a transfer");
    end

    // --------------------
    // pads at rest
    // --------------------
    a_oe_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_busy |-> (i_pad.dq_oe == 4'b0000)
    ) else begin
        fail_cnt++;
        $error("output enable set while idle");
    end

    a_sck_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_busy |-> (i_pad.sck == i_cfg.mode[1])
    ) else begin
        fail_cnt++;
        $error("sck away from its idle level while idle");
    end

endmodule

`default_nettype wire

/* testbench/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk
);
    localparam int HALF_NS = 10;                   // 20 ns period

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_NS);
            o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

/* src/qspi_master.sv */
`timescale 1ns/10ps
`default_nettype none

module qspi_master (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_req_valid,
    input  qspi_pkg::qspi_req_t i_req,
    input  qspi_pkg::qspi_cfg_t i_cfg,
    input  logic                i_rsp_ready,
    input  qspi_pkg::dq_t       i_dq,
    output logic                o_req_ready,
    output logic                o_rsp_valid,
    output qspi_pkg::byte_t     o_rsp_data,
    output logic                o_busy,
    output qspi_pkg::qspi_pad_t o_pad
);
    import qspi_pkg::*;

    logic      run;
    logic      edge_lead;
    logic      edge_trail;
    logic      load;
    logic      launch;
    logic      sample;
    logic      busy;
    qspi_req_t req_buf;

    // --------------------
    // clock generation
    // --------------------
    qspi_sck_gen u_sck_gen (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_run        (run),
        .i_div        (i_cfg.div),
        .i_cpol       (i_cfg.mode[1]),
        .o_sck        (o_pad.sck),
        .o_edge_lead  (edge_lead),
        .o_edge_trail (edge_trail)
    );

    qspi_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .i_cfg        (i_cfg),
        .i_rsp_ready  (i_rsp_ready),
        .i_edge_lead  (edge_lead),
        .i_edge_trail (edge_trail),
        .o_req_ready  (o_req_ready),
        .o_rsp_valid  (o_rsp_valid),
        .o_busy       (busy),
        .o_run        (run),
        .o_buf        (req_buf),
        .o_load       (load),
        .o_launch     (launch),
        .o_sample     (sample)
    );

    qspi_shifter u_shifter (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_buf        (req_buf),
        .i_load       (load),
        .i_active     (busy),
        .i_launch     (launch),
        .i_sample     (sample),
        .i_dq         (i_dq),
        .o_dq_o       (o_pad.dq_o),
        .o_dq_oe      (o_pad.dq_oe),
        .o_rx         (o_rsp_data)
    );

    assign o_busy = busy;

endmodule

`default_nettype wire

/* src/qspi_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module qspi_shifter (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  qspi_pkg::qspi_req_t i_buf,
    input  logic                i_load,
    input  logic                i_active,
    input  logic                i_launch,
    input  logic                i_sample,
    input  qspi_pkg::dq_t       i_dq,
    output qspi_pkg::dq_t       o_dq_o,
    output qspi_pkg::dq_t       o_dq_oe,
    output qspi_pkg::byte_t     o_rx
);
    import qspi_pkg::*;

    byte_t sh_q;
    byte_t rx_q;
    dq_t   oe_mask;

    // --------------------
    // transmit
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sh_q <= '0;
        end else if (i_load) begin
            sh_q <= i_buf.data;
        end else if (i_launch) begin
            case (i_buf.lanes)
                LANES_DUAL: sh_q <= sh_q << 2;
                LANES_QUAD: sh_q <= sh_q << 4;
                default:    sh_q <= sh_q << 1;
            endcase
        end
    end

    always_comb begin
        case (i_buf.lanes)
            LANES_DUAL: begin
                o_dq_o  = {2'b00, sh_q[BYTE_W-1 -: 2]};    // dq1 carries the msb
                oe_mask = i_buf.write ? 4'b0011 : 4'b0000;
            end
            LANES_QUAD: begin
                o_dq_o  = sh_q[BYTE_W-1 -: 4];
                oe_mask = i_buf.write ? 4'b1111 : 4'b0000;
            end
            default: begin
                o_dq_o  = {3'b000, sh_q[BYTE_W-1]};
                oe_mask = 4'b0001;                         // mosi on dq0
            end
        endcase
    end

    assign o_dq_oe = i_active ? oe_mask : '0;

    // --------------------
    // receive
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_sample) begin
            case (i_buf.lanes)
                LANES_DUAL: rx_q <= {rx_q[BYTE_W-3:0], i_dq[1:0]};
                LANES_QUAD: rx_q <= {rx_q[BYTE_W-5:0], i_dq};
                default:    rx_q <= {rx_q[BYTE_W-2:0], i_dq[1]};   // miso on dq1
            endcase
        end
    end

    assign o_rx = rx_q;

endmodule

`default_nettype wire

/* src/qspi_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module qspi_ctrl (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_req_valid,
    input  qspi_pkg::qspi_req_t i_req,
    input  qspi_pkg::qspi_cfg_t i_cfg,
    input  logic                i_rsp_ready,
    input  logic                i_edge_lead,
    input  logic                i_edge_trail,
    output logic                o_req_ready,
    output logic                o_rsp_valid,
    output logic                o_busy,
    output logic                o_run,
    output qspi_pkg::qspi_req_t o_buf,
    output logic                o_load,
    output logic                o_launch,
    output logic                o_sample
);
    import qspi_pkg::*;

    typedef logic [$clog2(2*BYTE_W)-1:0] edge_cnt_t;

    ctrl_state_e state_q;
    qspi_req_t   buf_q;
    edge_cnt_t   edge_cnt_q;
    edge_cnt_t   edge_last;
    logic        rsp_valid_q;
    logic        accept;
    logic        in_shift;
    logic        edge_any;
    logic        last_edge;
    logic        cpha;
    logic        single;
    logic        rsp_due;

    assign accept   = i_req_valid & o_req_ready;
    assign in_shift = (state_q == ST_SHIFT);
    assign edge_any = in_shift & (i_edge_lead | i_edge_trail);
    assign cpha     = i_cfg.mode[0];
    assign single   = (buf_q.lanes != LANES_DUAL) && (buf_q.lanes != LANES_QUAD);

    // --------------------
    // request buffer
    // --------------------
    always_ff @(posedge i_clk) begin
        if (accept) begin
            buf_q <= i_req;
        end
    end

    assign o_buf  = accept ? i_req : buf_q;        // shifter loads the new byte
    assign o_load = accept;

    // two edges per slot
    always_comb begin
        case (buf_q.lanes)
            LANES_DUAL: edge_last = edge_cnt_t'(BYTE_W - 1);
            LANES_QUAD: edge_last = edge_cnt_t'(BYTE_W/2 - 1);
            default:    edge_last = edge_cnt_t'(2*BYTE_W - 1);
        endcase
    end

    assign last_edge = edge_any & (edge_cnt_q == edge_last);
    assign rsp_due   = ~buf_q.write | (single & i_cfg.duplex);

    // --------------------
    // transfer FSM
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q     <= ST_IDLE;
            edge_cnt_q  <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q    <= ST_SHIFT;
                        edge_cnt_q <= '0;
                    end
                    if (rsp_valid_q && i_rsp_ready) begin
                        rsp_valid_q <= 1'b0;
                    end
                end
                ST_SHIFT: begin
                    if (last_edge) begin
                        state_q     <= ST_IDLE;
                        edge_cnt_q  <= '0;
                        rsp_valid_q <= rsp_due;
                    end else if (edge_any) begin
                        edge_cnt_q <= edge_cnt_q + edge_cnt_t'(1);
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign o_req_ready = (state_q == ST_IDLE) & ~rsp_valid_q;
    assign o_rsp_valid = rsp_valid_q;
    assign o_busy      = in_shift;
    assign o_run       = in_shift;

    // first leading edge with cpha=1 carries the preloaded bit
    assign o_launch = in_shift & (cpha ? (i_edge_lead & (edge_cnt_q != '0)) : i_edge_trail);
    assign o_sample = in_shift & (cpha ? i_edge_trail : i_edge_lead);

endmodule

`default_nettype wire

/* src/qspi_sck_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module qspi_sck_gen (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_run,
    input  qspi_pkg::div_t i_div,
    input  logic           i_cpol,
    output logic           o_sck,
    output logic           o_edge_lead,
    output logic           o_edge_trail
);
    import qspi_pkg::*;

    div_t              div_c;
    logic [HCNT_W-1:0] half_lim;
    logic [HCNT_W-1:0] cnt_q;
    logic              sck_q;
    logic              edge_hit;

    // --------------------
    // half period length
    // --------------------
    always_comb begin
        if (i_div > div_t'(DIV_MAX)) begin
            div_c = div_t'(DIV_MAX);               // clamp
        end else begin
            div_c = i_div;
        end
    end

    assign half_lim = (HCNT_W'(1) << div_c) - HCNT_W'(1);   // wraps to all ones for 2048

    assign edge_hit = i_run & (cnt_q == half_lim);

    // an edge away from the idle level is the leading one
    assign o_edge_lead  = edge_hit & (sck_q == i_cpol);
    assign o_edge_trail = edge_hit & (sck_q != i_cpol);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
            sck_q <= i_cpol;
        end else if (!i_run) begin
            cnt_q <= '0;
            sck_q <= i_cpol;                       // park at idle level
        end else if (edge_hit) begin
            cnt_q <= '0;
            sck_q <= ~sck_q;
        end else begin
            cnt_q <= cnt_q + HCNT_W'(1);
        end
    end

    assign o_sck = i_run ? sck_q : i_cpol;

endmodule

`default_nettype wire

/* src/qspi_pkg.sv */
`default_nettype none

package qspi_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int BYTE_W  = 8;
    localparam int LANE_N  = 4;                    // dq0..dq3
    localparam int DIV_W   = 4;
    localparam int DIV_MAX = 11;                   // half period of 2048 clocks at most
    localparam int HCNT_W  = 11;

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [LANE_N-1:0] dq_t;
    typedef logic [DIV_W-1:0]  div_t;
    typedef logic [1:0]        spi_mode_t;         // {cpol, cpha}

    // code 2'b11 is unused and treated as single
    typedef enum logic [1:0] {
        LANES_SINGLE = 2'b00,
        LANES_DUAL   = 2'b01,
        LANES_QUAD   = 2'b10
    } lanes_e;

    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_SHIFT = 1'b1
    } ctrl_state_e;

    // --------------------
    // grouped signals
    // --------------------
    typedef struct packed {
        logic   write;                             // low for a read
        lanes_e lanes;
        byte_t  data;
    } qspi_req_t;

    typedef struct packed {
        spi_mode_t mode;
        div_t      div;
        logic      duplex;                         // capture dq1 on single-lane writes
    } qspi_cfg_t;

    typedef struct packed {
        logic sck;
        dq_t  dq_o;
        dq_t  dq_oe;
    } qspi_pad_t;

endpackage

`default_nettype wire
